// ==== logic/controlPkg.sv ====
package controlPkg;

    // ====================
    // field types
    // ====================

    typedef logic [31:0] instrWordT;                // one fetched instruction
    typedef logic [4:0]  regAddrT;                  // rt / rs / rd register index

    // ====================
    // instruction encodings
    // ====================

    typedef enum logic [5:0] {
        OP_RTYPE  = 6'b000000,                      // decoded by funct
        OP_REGIMM = 6'b000001,                      // bltz or bgez picked by rt
        OP_J      = 6'b000010,
        OP_JAL    = 6'b000011,
        OP_BEQ    = 6'b000100,
        OP_BNE    = 6'b000101,
        OP_BLEZ   = 6'b000110,
        OP_BGTZ   = 6'b000111,
        OP_ADDI   = 6'b001000,
        OP_LUI    = 6'b001111,
        OP_LB     = 6'b100000,
        OP_LH     = 6'b100001,
        OP_LW     = 6'b100011,
        OP_SB     = 6'b101000,
        OP_SH     = 6'b101001,
        OP_SW     = 6'b101011
    } opcodeT;

    typedef enum logic [5:0] {
        FN_JR   = 6'b001000,                        // jump to R[rs]
        FN_MFHI = 6'b010000,
        FN_MTHI = 6'b010001,
        FN_MFLO = 6'b010010,
        FN_MTLO = 6'b010011
    } functT;

    // ====================
    // control field codes
    // ====================

    // alu operation codes numbered as the datapath ALU expects
    typedef enum logic [5:0] {
        ALU_AND  = 6'd0,
        ALU_ADD  = 6'd2,
        ALU_MTHI = 6'd10,
        ALU_MTLO = 6'd11,
        ALU_MFHI = 6'd12,
        ALU_MFLO = 6'd13,
        ALU_BEQ  = 6'd16,
        ALU_BGTZ = 6'd17,
        ALU_BGEZ = 6'd18,
        ALU_BLEZ = 6'd19,
        ALU_BLTZ = 6'd20,
        ALU_BNE  = 6'd21,
        ALU_LUI  = 6'd32                            // imm << 16
    } aluOpT;

    typedef enum logic [1:0] {
        DM_WORD = 2'd0,
        DM_HALF = 2'd1,
        DM_BYTE = 2'd2
    } dmModeT;

    typedef enum logic [1:0] {
        WD_RESULT = 2'd0,                           // memToReg mux output
        WD_LINK   = 2'd1,                           // write goes to $31
        WD_PC4    = 2'd3                            // return address
    } writeDstT;

    typedef enum logic [1:0] {
        JS_SEQ    = 2'd0,                           // pc+4 or branch target
        JS_REG    = 2'd1,                           // R[rs]
        JS_TARGET = 2'd2                            // 26-bit jump field
    } jumpSelT;

    // ====================
    // control word
    // ====================

    typedef struct packed {
        logic     regDst;                           // rd instead of rt
        logic     branch;
        logic     memRead;
        logic     memToReg;                         // 1 picks alu result
        logic     memWrite;
        logic     aluSrc2;                          // immExt on alu B
        logic     aluSrc1;                          // shamt on alu A
        logic     regWrite;
        logic     signExt;                          // 0 means zero extend
        logic     condMov;                          // always 0 without movn/movz
        aluOpT    aluOp;
        dmModeT   dmMode;
        writeDstT writeDst;
        jumpSelT  jumpSel;
    } ctrlWordT;                                    // 22 bits

    // bubble / reset word
    localparam ctrlWordT IDLE_CTRL = '{
        regDst:   1'b0,
        branch:   1'b0,
        memRead:  1'b0,
        memToReg: 1'b0,
        memWrite: 1'b0,
        aluSrc2:  1'b0,
        aluSrc1:  1'b0,
        regWrite: 1'b0,
        signExt:  1'b0,
        condMov:  1'b0,
        aluOp:    ALU_AND,
        dmMode:   DM_WORD,
        writeDst: WD_RESULT,
        jumpSel:  JS_SEQ
    };

    // r-type and and the fallback for opcodes nobody knows
    localparam ctrlWordT AND_CTRL = '{
        regDst:   1'b1,
        branch:   1'b0,
        memRead:  1'b0,
        memToReg: 1'b1,
        memWrite: 1'b0,
        aluSrc2:  1'b0,
        aluSrc1:  1'b0,
        regWrite: 1'b1,
        signExt:  1'b0,
        condMov:  1'b0,
        aluOp:    ALU_AND,
        dmMode:   DM_WORD,
        writeDst: WD_RESULT,
        jumpSel:  JS_SEQ
    };

endpackage

// ==== logic/opcodeDecoder.sv ====
`timescale 1ns/10ps

module opcodeDecoder (
    input  controlPkg::opcodeT   op,                // instr[31:26]
    input  controlPkg::regAddrT  rt,                // instr[20:16], regimm selector
    output logic                 isRType,
    output controlPkg::ctrlWordT primaryCtrl
);

    // access width for loads and stores
    function automatic controlPkg::dmModeT accessWidth(input controlPkg::opcodeT code);
        controlPkg::dmModeT width;
        case (code)
            controlPkg::OP_LB, controlPkg::OP_SB: width = controlPkg::DM_BYTE;
            controlPkg::OP_LH, controlPkg::OP_SH: width = controlPkg::DM_HALF;
            default:                              width = controlPkg::DM_WORD;
        endcase
        return width;
    endfunction

    assign isRType = (op == controlPkg::OP_RTYPE);  // funct decoder owns these

    always_comb begin
        primaryCtrl = controlPkg::IDLE_CTRL;        // every class starts idle
        case (op)
            // ====================
            // memory
            // ====================
            controlPkg::OP_LW, controlPkg::OP_LH, controlPkg::OP_LB: begin
                primaryCtrl.memRead  = 1'b1;
                primaryCtrl.aluSrc2  = 1'b1;        // base + offset
                primaryCtrl.regWrite = 1'b1;
                primaryCtrl.signExt  = 1'b1;
                primaryCtrl.aluOp    = controlPkg::ALU_ADD;
                primaryCtrl.dmMode   = accessWidth(op);
            end
            controlPkg::OP_LUI: begin
                primaryCtrl.memRead  = 1'b1;        // kept from word load
                primaryCtrl.aluSrc2  = 1'b1;
                primaryCtrl.regWrite = 1'b1;
                primaryCtrl.signExt  = 1'b1;
                primaryCtrl.aluOp    = controlPkg::ALU_LUI;
                primaryCtrl.dmMode   = controlPkg::DM_WORD;
            end
            controlPkg::OP_SW, controlPkg::OP_SH, controlPkg::OP_SB: begin
                primaryCtrl.memWrite = 1'b1;
                primaryCtrl.aluSrc2  = 1'b1;        // address = base + offset
                primaryCtrl.signExt  = 1'b1;
                primaryCtrl.aluOp    = controlPkg::ALU_ADD;
                primaryCtrl.dmMode   = accessWidth(op);
            end

            // ====================
            // control flow
            // ====================
            controlPkg::OP_BEQ, controlPkg::OP_BNE,
            controlPkg::OP_BGTZ, controlPkg::OP_BLEZ,
            controlPkg::OP_REGIMM: begin
                primaryCtrl.branch  = 1'b1;
                primaryCtrl.signExt = 1'b1;         // signed word offset
                case (op)
                    controlPkg::OP_BEQ:  primaryCtrl.aluOp = controlPkg::ALU_BEQ;
                    controlPkg::OP_BNE:  primaryCtrl.aluOp = controlPkg::ALU_BNE;
                    controlPkg::OP_BGTZ: primaryCtrl.aluOp = controlPkg::ALU_BGTZ;
                    controlPkg::OP_BLEZ: primaryCtrl.aluOp = controlPkg::ALU_BLEZ;
                    default: begin
                        // regimm uses rt 00001 for bgez and 00000 for bltz
                        primaryCtrl.aluOp = rt[0] ? controlPkg::ALU_BGEZ
                                                  : controlPkg::ALU_BLTZ;
                    end
                endcase
            end
            controlPkg::OP_J, controlPkg::OP_JAL: begin
                primaryCtrl.signExt = 1'b1;
                primaryCtrl.jumpSel = controlPkg::JS_TARGET;
                if (op == controlPkg::OP_JAL) begin
                    primaryCtrl.writeDst = controlPkg::WD_LINK;  // link into $31
                end
            end

            // ====================
            // immediate / other
            // ====================
            controlPkg::OP_ADDI: begin
                primaryCtrl.memToReg = 1'b1;        // alu result to rt
                primaryCtrl.aluSrc2  = 1'b1;
                primaryCtrl.regWrite = 1'b1;
                primaryCtrl.signExt  = 1'b1;
                primaryCtrl.aluOp    = controlPkg::ALU_ADD;
            end
            controlPkg::OP_RTYPE: begin
                primaryCtrl = controlPkg::IDLE_CTRL;  // rtype word wins in the stage reg
            end
            default: begin
                primaryCtrl = controlPkg::AND_CTRL;   // unknown op acts as and
            end
        endcase
    end

endmodule

// ==== logic/functDecoder.sv ====
`timescale 1ns/10ps

module functDecoder (
    input  controlPkg::functT    funct,             // instr[5:0]
    output controlPkg::ctrlWordT rtypeCtrl
);

    // ====================
    // r-type word
    // ====================

    always_comb begin
        rtypeCtrl = controlPkg::AND_CTRL;           // rd <= rs op rt base
        case (funct)
            // hi/lo moves only swap the alu code
            controlPkg::FN_MTHI: begin
                rtypeCtrl.aluOp = controlPkg::ALU_MTHI;
            end
            controlPkg::FN_MTLO: begin
                rtypeCtrl.aluOp = controlPkg::ALU_MTLO;
            end
            controlPkg::FN_MFHI: begin
                rtypeCtrl.aluOp = controlPkg::ALU_MFHI;
            end
            controlPkg::FN_MFLO: begin
                rtypeCtrl.aluOp = controlPkg::ALU_MFLO;
            end

            // register jump writes nothing back
            controlPkg::FN_JR: begin
                rtypeCtrl         = controlPkg::IDLE_CTRL;
                rtypeCtrl.signExt = 1'b1;
                rtypeCtrl.jumpSel = controlPkg::JS_REG;  // pc <= R[rs]
            end

            default: begin
                rtypeCtrl = controlPkg::AND_CTRL;   // unlisted funct decodes as and
            end
        endcase
    end

endmodule

// ==== logic/decodeStageReg.sv ====
`timescale 1ns/10ps

module decodeStageReg (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 instrValid,
    input  logic                 isRType,           // pick funct word
    input  controlPkg::ctrlWordT primaryCtrl,
    input  controlPkg::ctrlWordT rtypeCtrl,
    output controlPkg::ctrlWordT ctrl,
    output logic                 ctrlValid
);

    controlPkg::ctrlWordT nextCtrl;                 // word for the coming edge

    // ====================
    // word select
    // ====================

    always_comb begin
        if (!instrValid) begin
            nextCtrl = controlPkg::IDLE_CTRL;       // bubble
        end else if (isRType) begin
            nextCtrl = rtypeCtrl;
        end else begin
            nextCtrl = primaryCtrl;
        end
    end

    // ====================
    // id/ex register
    // ====================

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrl      <= controlPkg::IDLE_CTRL;
            ctrlValid <= 1'b0;
        end else begin
            ctrl      <= nextCtrl;                  // new word every cycle
            ctrlValid <= instrValid;                // no stall path
        end
    end

endmodule

// ==== logic/mipsControl.sv ====
`timescale 1ns/10ps

module mipsControl (
    input  logic                  clk,
    input  logic                  rstN,
    input  controlPkg::instrWordT instr,
    input  logic                  instrValid,
    output controlPkg::ctrlWordT  ctrl,             // one cycle after instr
    output logic                  ctrlValid
);

    controlPkg::opcodeT   opField;                  // instr[31:26]
    controlPkg::regAddrT  rtField;                  // instr[20:16]
    controlPkg::functT    functField;               // instr[5:0]
    controlPkg::ctrlWordT primaryCtrl;
    controlPkg::ctrlWordT rtypeCtrl;
    logic                 isRType;

    // field slicing
    assign opField    = controlPkg::opcodeT'(instr[31:26]);
    assign rtField    = instr[20:16];
    assign functField = controlPkg::functT'(instr[5:0]);

    opcodeDecoder uOpcodeDecoder (
        .op          (opField),
        .rt          (rtField),
        .isRType     (isRType),
        .primaryCtrl (primaryCtrl)
    );

    functDecoder uFunctDecoder (
        .funct     (functField),
        .rtypeCtrl (rtypeCtrl)
    );

    decodeStageReg uDecodeStageReg (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .isRType     (isRType),
        .primaryCtrl (primaryCtrl),
        .rtypeCtrl   (rtypeCtrl),
        .ctrl        (ctrl),
        .ctrlValid   (ctrlValid)
    );

endmodule

// ==== verification/controlVectors.svh ====
// each row holds a test name, an instruction word and the expected 22-bit control word
// flag bit order is regDst branch memRead memToReg memWrite aluSrc2 aluSrc1 regWrite
// signExt condMov
localparam logic [9:0] LOAD_FLAGS   = 10'b0010010110;   // lui shares these
localparam logic [9:0] STORE_FLAGS  = 10'b0000110010;   // memWrite without regWrite
localparam logic [9:0] BRANCH_FLAGS = 10'b0100000010;
localparam logic [9:0] JUMP_FLAGS   = 10'b0000000010;   // j, jal, jr
localparam logic [9:0] ADDI_FLAGS   = 10'b0001010110;
localparam logic [9:0] AND_FLAGS    = 10'b1001000100;   // r-type base and unknown op

string       vecName[$];
logic [31:0] vecInstr[$];
logic [21:0] vecExpect[$];

// {flags, aluOp, dmMode, writeDst, jumpSel}
function automatic logic [21:0] packCtrl(input logic [9:0] flags, input logic [5:0] aluOp,
                                         input logic [1:0] dm, input logic [1:0] wd,
                                         input logic [1:0] js);
    return {flags, aluOp, dm, wd, js};
endfunction

function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rt,
                                      input logic [15:0] imm);
    return {op, 5'd4, rt, imm};                         // rs fixed at $a0
endfunction

function automatic logic [31:0] rType(input logic [5:0] funct);
    return {6'd0, 5'd9, 5'd10, 5'd11, 5'd0, funct};     // rd $t3 with rs $t1 and rt $t2
endfunction

task automatic addRow(input string name, input logic [31:0] word, input logic [21:0] expWord);
    vecName.push_back(name);
    vecInstr.push_back(word);
    vecExpect.push_back(expWord);
endtask

task automatic loadVectors();
    addRow("lw", iType(6'h23, 5'd8, 16'h0004), packCtrl(LOAD_FLAGS, 6'd2, 2'd0, 2'd0, 2'd0));
    addRow("lh", iType(6'h21, 5'd8, 16'h0002), packCtrl(LOAD_FLAGS, 6'd2, 2'd1, 2'd0, 2'd0));
    addRow("lb", iType(6'h20, 5'd8, 16'hffff), packCtrl(LOAD_FLAGS, 6'd2, 2'd2, 2'd0, 2'd0));
    addRow("lui", iType(6'h0f, 5'd8, 16'h1234), packCtrl(LOAD_FLAGS, 6'd32, 2'd0, 2'd0, 2'd0));
    addRow("sw", iType(6'h2b, 5'd9, 16'h0010), packCtrl(STORE_FLAGS, 6'd2, 2'd0, 2'd0, 2'd0));
    addRow("sh", iType(6'h29, 5'd9, 16'h0012), packCtrl(STORE_FLAGS, 6'd2, 2'd1, 2'd0, 2'd0));
    addRow("sb", iType(6'h28, 5'd9, 16'h0013), packCtrl(STORE_FLAGS, 6'd2, 2'd2, 2'd0, 2'd0));
    addRow("beq", iType(6'h04, 5'd5, 16'h0020), packCtrl(BRANCH_FLAGS, 6'd16, 2'd0, 2'd0, 2'd0));
    addRow("bne", iType(6'h05, 5'd5, 16'hfff0), packCtrl(BRANCH_FLAGS, 6'd21, 2'd0, 2'd0, 2'd0));
    addRow("bgtz", iType(6'h07, 5'd0, 16'h0008), packCtrl(BRANCH_FLAGS, 6'd17, 2'd0, 2'd0, 2'd0));
    addRow("blez", iType(6'h06, 5'd0, 16'h0008), packCtrl(BRANCH_FLAGS, 6'd19, 2'd0, 2'd0, 2'd0));
    addRow("bgez", iType(6'h01, 5'd1, 16'hfffc), packCtrl(BRANCH_FLAGS, 6'd18, 2'd0, 2'd0, 2'd0));
    addRow("bltz", iType(6'h01, 5'd0, 16'h0004), packCtrl(BRANCH_FLAGS, 6'd20, 2'd0, 2'd0, 2'd0));
    addRow("j", iType(6'h02, 5'd0, 16'h0040), packCtrl(JUMP_FLAGS, 6'd0, 2'd0, 2'd0, 2'd2));
    addRow("jal", iType(6'h03, 5'd0, 16'h0080), packCtrl(JUMP_FLAGS, 6'd0, 2'd0, 2'd1, 2'd2));
    addRow("addi", iType(6'h08, 5'd8, 16'h0007), packCtrl(ADDI_FLAGS, 6'd2, 2'd0, 2'd0, 2'd0));
    addRow("mthi", rType(6'h11), packCtrl(AND_FLAGS, 6'd10, 2'd0, 2'd0, 2'd0));
    addRow("mtlo", rType(6'h13), packCtrl(AND_FLAGS, 6'd11, 2'd0, 2'd0, 2'd0));
    addRow("mfhi", rType(6'h10), packCtrl(AND_FLAGS, 6'd12, 2'd0, 2'd0, 2'd0));
    addRow("mflo", rType(6'h12), packCtrl(AND_FLAGS, 6'd13, 2'd0, 2'd0, 2'd0));
    addRow("jr", rType(6'h08), packCtrl(JUMP_FLAGS, 6'd0, 2'd0, 2'd0, 2'd1));
    addRow("funct add", rType(6'h20), packCtrl(AND_FLAGS, 6'd0, 2'd0, 2'd0, 2'd0));  // dropped
    addRow("opcode ori", iType(6'h0d, 5'd8, 16'h00ff), packCtrl(AND_FLAGS, 6'd0, 2'd0, 2'd0, 2'd0));
endtask

// ==== verification/controlTb.sv ====
`timescale 1ns/10ps

module controlTb;

    logic                  clk;
    logic                  rstN;
    controlPkg::instrWordT instr;
    logic                  instrValid;
    controlPkg::ctrlWordT  ctrl;
    logic                  ctrlValid;

    int          passCount;
    int          failCount;
    int          waited;                            // extra falling edges before valid
    int          row;
    bit          havePending;                       // a row still owes its output cycle
    string       pendName;
    bit          pendValid;
    logic [21:0] pendWord;

    localparam logic [21:0] IDLE_WORD = 22'd0;      // bubble and reset word

    `include "controlVectors.svh"

    mipsControl dut (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .instrValid (instrValid),
        .ctrl       (ctrl),
        .ctrlValid  (ctrlValid)
    );

    always #10 clk = ~clk;                          // 20 ns period

    task automatic checkResult(input string name, input bit expValid, input logic [21:0] expWord);
        if (ctrlValid !== expValid) begin
            $display("Fail %s ctrlValid expected %b actual %b", name, expValid, ctrlValid);
            failCount++;
        end else if (ctrl !== expWord) begin
            $display("Fail %s expected %h actual %h", name, expWord, ctrl);
            failCount++;
        end else begin
            $display("Pass %s", name);
            passCount++;
        end
    endtask

    // drive on the rising edge and check the previous row at the falling edge
    task automatic issueCycle(input bit valid, input logic [31:0] word, input string name,
                              input logic [21:0] expWord);
        @(posedge clk);
        instrValid <= valid;
        instr      <= word;
        @(negedge clk);
        if (havePending) begin
            checkResult(pendName, pendValid, pendWord);
        end
        havePending = 1'b1;
        pendName    = name;
        pendValid   = valid;
        pendWord    = valid ? expWord : IDLE_WORD;
    endtask

    initial begin
        clk         = 1'b0;
        rstN        = 1'b0;
        instr       = '0;
        instrValid  = 1'b0;
        passCount   = 0;
        failCount   = 0;
        havePending = 1'b0;
        void'($urandom(32'hc8f));                   // one seed for the whole run
        loadVectors();

        // ====================
        // reset
        // ====================
        repeat (2) @(posedge clk);
        @(negedge clk);
        checkResult("in reset", 1'b0, IDLE_WORD);
        repeat (2) @(posedge clk);
        rstN <= 1'b1;                               // released after 4 cycles
        @(negedge clk);
        checkResult("after reset", 1'b0, IDLE_WORD);

        // ====================
        // single pulse latency
        // ====================
        @(posedge clk);
        instr      <= vecInstr[0];
        instrValid <= 1'b1;
        @(posedge clk);
        instrValid <= 1'b0;                         // lw sampled on this edge
        waited = 0;
        @(negedge clk);
        while (ctrlValid !== 1'b1 && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (ctrlValid !== 1'b1) begin
            $display("Timeout: the ctrl output never became valid after an instruction");
            failCount++;
        end else if (waited != 0) begin
            $display("Fail latency expected 0 extra cycles actual %0d", waited);
            failCount++;
        end else begin
            checkResult("latency lw", 1'b1, vecExpect[0]);
        end

        // ====================
        // table, back to back
        // ====================
        for (row = 0; row < vecName.size(); row++) begin
            if ($urandom_range(3) == 0 || row % 8 == 5) begin
                issueCycle(1'b0, $urandom, $sformatf("bubble before %s", vecName[row]), IDLE_WORD);
            end
            issueCycle(1'b1, vecInstr[row], vecName[row], vecExpect[row]);
        end
        issueCycle(1'b0, $urandom, "tail bubble", IDLE_WORD);
        @(posedge clk);
        @(negedge clk);
        checkResult(pendName, pendValid, pendWord);

        $display("%0d passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+verification
logic/controlPkg.sv
logic/opcodeDecoder.sv
logic/functDecoder.sv
logic/decodeStageReg.sv
logic/mipsControl.sv
verification/controlTb.sv
